// ==== AluCore.sv ====
`timescale 1ns/1ns

`include "core_params.svh"

module AluCore
	import aluPkg::*;
(
	input  logic               CLK,      // Core clock
	input  logic               arstN,
	input  logic [`DATA_W-1:0] dl,       // Internal data bus
	input  aluCtl_t            aluCtl,   // From OpDecoder
	input  logic               useCarry, // Carry mode from BusCfg
	output logic [`DATA_W-1:0] res,      // Combinational ALU result
	output logic [`DATA_W-1:0] dv,       // Operand latch
	output logic [`DATA_W-1:0] acc,      // Accumulator
	output flags_t             flags
);

	logic [`DATA_W:0] sum;      // Result with carry or borrow on top
	logic             carryIn;  // Stored carry joining the add
	logic             aluCarry; // Carry out of this op

	// ADC always takes the carry, ADD only in carry mode
	assign carryIn = flags.carry &
		((aluCtl.op == ADC) | ((aluCtl.op == ADD) & useCarry));

	always_comb begin
		case (aluCtl.op)
			ADD, ADC: begin
				sum = {1'b0, acc} + {1'b0, dv} + {{`DATA_W{1'b0}}, carryIn};
			end
			SUB: begin
				sum = {1'b0, acc} - {1'b0, dv};  // Top bit set on borrow
			end
			AND: begin
				sum = {1'b0, acc & dv};
			end
			XOR: begin
				sum = {1'b0, acc ^ dv};
			end
			PASSA: begin
				sum = {1'b0, acc};            // Store source
			end
			default: begin
				sum = {1'b0, dv};             // PASSB, load immediate
			end
		endcase
	end

	assign res      = sum[`DATA_W-1:0];
	assign aluCarry = sum[`DATA_W];

	// Operand latch fills from DL during OPERAND
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			dv <= `DATA_RESET;
		end else if (aluCtl.loadDv) begin
			dv <= dl;
		end
	end

	// Accumulator takes DL, which carries Res during EXEC
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			acc   <= `DATA_RESET;
			flags <= '0;
		end else if (aluCtl.loadAcc) begin
			acc         <= dl;
			flags.zero  <= (dl == '0);   // Zero of the value written back
			flags.carry <= aluCarry;     // Logic ops and loads clear it
		end
	end

endmodule : AluCore

// ==== BusCfg.sv ====
`timescale 1ns/1ns

`include "core_params.svh"

module BusCfg
	import aluPkg::*;
(
	input  logic CLK,      // Core clock
	input  logic arstN,
	input  logic cfgWe,    // Write strobe, level
	input  cfg_t cfgWdata,
	output cfg_t cfg,      // Live configuration
	output cfg_t cfgRdata  // Readback, one cycle behind cfg
);

	// Configuration register
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			cfg <= cfg_t'(`CFG_RESET);
		end else if (cfgWe) begin
			cfg <= cfgWdata;
		end
	end

	// Registered readback port
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			cfgRdata <= cfg_t'(`CFG_RESET);
		end else begin
			cfgRdata <= cfg;
		end
	end

endmodule : BusCfg

// ==== DataMux.sv ====
`timescale 1ns/1ns

`include "core_params.svh"

module DataMux
	import busPkg::*;
(
	input  logic               CLK,        // Core clock
	input  logic               arstN,
	input  logic [`DATA_W-1:0] dataIn,     // External bus input side
	input  muxCtl_t            muxCtl,     // From OpDecoder
	input  logic               busDisable, // Test1, from BusCfg
	input  logic [`DATA_W-1:0] res,        // ALU result, always valid
	input  logic [`DATA_W-1:0] dv,         // ALU operand latch
	output logic [`DATA_W-1:0] dl,         // Internal data bus
	output logic [`DATA_W-1:0] dataOut,    // External bus output side
	output logic               dataOe      // External output enable
);

	logic [`DATA_W-1:0] keepQ;   // Bus keeper, holds last DL
	logic               extToDl; // External byte owns DL

	// Inward path only when not writing and the bus is connected
	assign extToDl = ~muxCtl.busWr & ~busDisable;

	// DL resolution by priority
	always_comb begin
		if (extToDl) begin
			dl = dataIn;           // Read cycle
		end else if (muxCtl.resToDl) begin
			dl = res;              // ALU result or PASSA for stores
		end else if (muxCtl.dvToDl) begin
			dl = dv;               // OUTDV source
		end else begin
			dl = keepQ;            // Nobody drives, keeper holds
		end
	end

	// Keeper stands in for the transparent latches of the real bus
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			keepQ <= `DATA_RESET;
		end else begin
			keepQ <= dl;
		end
	end

	// Outward drive uses the kept byte so it is stable the whole cycle
	assign dataOut = keepQ;

	// Drive out once DL has settled on its kept value in write direction
	// The cycle that loads DL keeps the external bus released
	assign dataOe = muxCtl.busWr & muxCtl.dlKeep & ~busDisable;

endmodule : DataMux

// ==== DataPathTop.sv ====
`timescale 1ns/1ns

`include "core_params.svh"

module DataPathTop
	import busPkg::*;
	import aluPkg::*;
(
	input  logic               CLK,       // Core clock
	input  logic               arstN,
	input  logic [`DATA_W-1:0] dataIn,    // External bus, inward
	input  logic               cfgWe,
	input  cfg_t               cfgWdata,
	output logic [`DATA_W-1:0] dataOut,   // External bus, outward
	output logic               dataOe,
	output logic               busRd,     // Decoder samples the bus
	output logic [`DATA_W-1:0] acc,
	output flags_t             flags,
	output cfg_t               cfgRdata
);

	muxCtl_t            muxCtl;
	aluCtl_t            aluCtl;
	cfg_t               cfg;
	logic [`DATA_W-1:0] dl;   // Internal data bus
	logic [`DATA_W-1:0] res;  // ALU result
	logic [`DATA_W-1:0] dv;   // ALU operand

	OpDecoder u_OpDecoder (
		.CLK    (CLK),
		.arstN  (arstN),
		.dl     (dl),
		.muxCtl (muxCtl),
		.aluCtl (aluCtl),
		.busRd  (busRd)
	);

	BusCfg u_BusCfg (
		.CLK      (CLK),
		.arstN    (arstN),
		.cfgWe    (cfgWe),
		.cfgWdata (cfgWdata),
		.cfg      (cfg),
		.cfgRdata (cfgRdata)
	);

	AluCore u_AluCore (
		.CLK      (CLK),
		.arstN    (arstN),
		.dl       (dl),
		.aluCtl   (aluCtl),
		.useCarry (cfg.useCarry),
		.res      (res),
		.dv       (dv),
		.acc      (acc),
		.flags    (flags)
	);

	DataMux u_DataMux (
		.CLK        (CLK),
		.arstN      (arstN),
		.dataIn     (dataIn),
		.muxCtl     (muxCtl),
		.busDisable (cfg.busDisable),
		.res        (res),
		.dv         (dv),
		.dl         (dl),
		.dataOut    (dataOut),
		.dataOe     (dataOe)
	);

endmodule : DataPathTop

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tbDataPath
FILELIST   = files.f
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
OBJDIR     = obj_dir
LOG        = sim.log
FAIL_MSG   = Some tests failed
PASS_MSG   = All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== OpDecoder.sv ====
`timescale 1ns/1ns

`include "core_params.svh"

module OpDecoder
	import busPkg::*;
	import aluPkg::*;
(
	input  logic               CLK,    // Core clock
	input  logic               arstN,
	input  logic [`DATA_W-1:0] dl,     // Opcode and immediates arrive here
	output muxCtl_t            muxCtl, // To DataMux
	output aluCtl_t            aluCtl, // To AluCore
	output logic               busRd   // Byte sampled at this edge
);

	decState_t state;
	decState_t nextState;
	aluOp_t    opReg;  // Operation of the running instruction
	aluOp_t    opDec;  // Operation decoded from DL in FETCH

	// Opcode byte to ALU operation
	always_comb begin
		case (dl)
			`OP_ADD: opDec = ADD;
			`OP_ADC: opDec = ADC;
			`OP_SUB: opDec = SUB;
			`OP_AND: opDec = AND;
			`OP_XOR: opDec = XOR;
			`OP_ST:  opDec = PASSA;  // Accumulator onto DL
			default: opDec = PASSB;  // LDI and OUTDV, others unused
		endcase
	end

	// Sequencing, only FETCH branches
	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH: begin
				case (dl)
					`OP_LDI, `OP_ADD, `OP_ADC, `OP_SUB, `OP_AND, `OP_XOR: begin
						nextState = OPERAND;
					end
					`OP_ST, `OP_OUTDV: begin
						nextState = WRITE1;
					end
					`OP_NOP: begin
						nextState = FETCH;
					end
					default: begin
						nextState = FETCH;  // Unknown bytes run as NOP
					end
				endcase
			end
			OPERAND: nextState = EXEC;
			WRITE1:  nextState = WRITE2;
			default: nextState = FETCH;     // EXEC and WRITE2 end the instruction
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= FETCH;
			opReg <= PASSB;
		end else begin
			state <= nextState;
			if (state == FETCH) begin
				opReg <= opDec;  // Held through the remaining M-cycles
			end
		end
	end

	// Per-cycle control levels
	always_comb begin
		muxCtl = '0;
		aluCtl = '{op: PASSB, loadDv: 1'b0, loadAcc: 1'b0};
		busRd  = 1'b0;
		case (state)
			FETCH: begin
				busRd = 1'b1;           // DL follows dataIn
			end
			OPERAND: begin
				busRd         = 1'b1;
				aluCtl.loadDv = 1'b1;   // Immediate into DV
			end
			EXEC: begin
				muxCtl.busWr   = 1'b1;  // WR hack, releases DL from dataIn
				muxCtl.resToDl = 1'b1;
				aluCtl.op      = opReg;
				aluCtl.loadAcc = 1'b1;
			end
			WRITE1: begin
				muxCtl.busWr   = 1'b1;
				muxCtl.resToDl = (opReg == PASSA);  // ST
				muxCtl.dvToDl  = (opReg != PASSA);  // OUTDV
				aluCtl.op      = opReg;
			end
			WRITE2: begin
				muxCtl.busWr  = 1'b1;
				muxCtl.dlKeep = 1'b1;   // Kept byte goes out
			end
			default: begin
				busRd = 1'b0;
			end
		endcase
	end

endmodule : OpDecoder

// ==== aluPkg.sv ====
// Types shared by the ALU side of the core
// Covers the ALU opcodes and controls, the flags and the configuration word

package aluPkg;

	// Operation selected on the ALU result bus
	typedef enum logic [2:0] {
		PASSB = 3'd0,    // Res is DV, used by LDI
		ADD   = 3'd1,    // Carry joins only in carry mode
		ADC   = 3'd2,    // Always adds the stored carry
		SUB   = 3'd3,    // Carry flag holds the borrow
		AND   = 3'd4,
		XOR   = 3'd5,
		PASSA = 3'd6     // Res is the accumulator, used by ST
	} aluOp_t;

	typedef struct packed {
		aluOp_t op;      // Result selection
		logic   loadDv;  // DL into DV at the clock edge
		logic   loadAcc; // DL into the accumulator, flags follow
	} aluCtl_t;

	typedef struct packed {
		logic zero;
		logic carry;     // Carry out or borrow of the last ALU op
	} flags_t;

	// Configuration word held by BusCfg
	typedef struct packed {
		logic busDisable; // Test1 equivalent, core cut off the external bus
		logic useCarry;   // ADD takes the carry like ADC
	} cfg_t;

endpackage : aluPkg

// ==== busPkg.sv ====
// Types shared by the bus side of the core
// Covers the data bus multiplexer controls and the decoder M-cycle states

package busPkg;

	// Controls for DataMux, set by OpDecoder every cycle
	typedef struct packed {
		logic busWr;     // External direction, 1 drives out
		logic resToDl;   // ALU result onto DL
		logic dvToDl;    // DV latch onto DL
		logic dlKeep;    // DL idles on its kept value
	} muxCtl_t;

	// M-cycle states of the instruction sequencer
	typedef enum logic [2:0] {
		FETCH   = 3'd0,  // Opcode sampled from the external bus
		OPERAND = 3'd1,  // Immediate byte latched into DV
		EXEC    = 3'd2,  // Result written back to the accumulator
		WRITE1  = 3'd3,  // Source placed onto DL
		WRITE2  = 3'd4   // Kept DL driven onto the external bus
	} decState_t;

endpackage : busPkg

// ==== core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of the internal DL bus and the external data bus
`define DATA_W      8

// Opcode bytes seen on the external bus
`define OP_NOP      8'h00
`define OP_LDI      8'h3E   // LD A,n
`define OP_ADD      8'hC6   // ADD A,n
`define OP_ADC      8'hCE   // ADC A,n
`define OP_SUB      8'hD6   // SUB n
`define OP_AND      8'hE6   // AND n
`define OP_XOR      8'hEE   // XOR n
`define OP_ST       8'h02   // Accumulator out to the bus
`define OP_OUTDV    8'hD3   // Unused slot on the real part, DV out

// Reset values
`define DATA_RESET  8'h00   // Accumulator, DV and bus keeper
`define CFG_RESET   2'b00   // Bus enabled, plain ADD

`endif

// ==== files.f ====
+incdir+.
busPkg.sv
aluPkg.sv
DataMux.sv
AluCore.sv
OpDecoder.sv
BusCfg.sv
DataPathTop.sv
tbDataPath.sv

// ==== tbDataPath.sv ====
`timescale 1ns/1ns

`include "core_params.svh"

module tbDataPath
	import aluPkg::*;
();

	localparam int PROG_LEN   = 60;                        // Instructions and config slots
	localparam int MAX_CYCLES = 4 * (PROG_LEN * 3 + 40);   // Run limit in clock cycles

	logic               CLK;
	logic               arstN;
	logic [`DATA_W-1:0] dataIn;
	logic               cfgWe;
	cfg_t               cfgWdata;
	logic [`DATA_W-1:0] dataOut;
	logic               dataOe;
	logic               busRd;
	logic [`DATA_W-1:0] acc;
	flags_t             flags;
	cfg_t               cfgRdata;

	logic [`DATA_W-1:0] modelAcc;      // Reference accumulator
	logic [`DATA_W-1:0] modelDv;       // Reference operand latch
	logic               modelZero;
	logic               modelCarry;
	logic               modelUseCarry; // Carry mode as last written
	logic               disabledPhase; // Bus cut off by the configuration
	int                 checkCount   = 0;
	int                 errCount     = 0;
	int                 propErrCount = 0; // Failures of the concurrent properties
	int                 cycleCount   = 0;

	DataPathTop u_DataPathTop (
		.CLK      (CLK),
		.arstN    (arstN),
		.dataIn   (dataIn),
		.cfgWe    (cfgWe),
		.cfgWdata (cfgWdata),
		.dataOut  (dataOut),
		.dataOe   (dataOe),
		.busRd    (busRd),
		.acc      (acc),
		.flags    (flags),
		.cfgRdata (cfgRdata)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;   // 100 ns period
	end

	// Run limit
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("Timeout: run still going after %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// Store pulse lasts one cycle only
	assert property (@(posedge CLK) disable iff (!arstN) dataOe |=> !dataOe)
		else begin
			propErrCount++;
			$display("[ERROR] %0t dataOe got 1 expected 0 after a one cycle pulse", $time);
		end

	// Never drive while the decoder samples the bus
	assert property (@(posedge CLK) disable iff (!arstN) dataOe |-> !busRd)
		else begin
			propErrCount++;
			$display("[ERROR] %0t busRd got 1 expected 0 while dataOe is high", $time);
		end

	assert property (@(posedge CLK) disable iff (!arstN) disabledPhase |-> !dataOe)
		else begin
			propErrCount++;
			$display("[ERROR] %0t dataOe got 1 expected 0 with the bus disabled", $time);
		end

	assert property (@(posedge CLK) disable iff (!arstN) disabledPhase |=> $stable(acc))
		else begin
			propErrCount++;
			$display("[ERROR] %0t acc changed with the bus disabled", $time);
		end

	// Inputs change 10 ns after the rising edge
	task automatic nextCycle();
		@(posedge CLK);
		#10;
	endtask

	function automatic logic [`DATA_W-1:0] randByte();
		logic [31:0] rnd;
		rnd = $urandom();
		return rnd[`DATA_W-1:0];
	endfunction

	task automatic checkByte(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// Reference model of one operand instruction
	task automatic modelExec(input logic [`DATA_W-1:0] op, input logic [`DATA_W-1:0] imm);
		int   total;
		logic cin;
		cin     = 1'b0;
		total   = int'(imm);                 // LDI passes the immediate
		modelDv = imm;
		case (op)
			`OP_ADD, `OP_ADC: begin
				if (op == `OP_ADC || modelUseCarry) begin
					cin = modelCarry;
				end
				total = int'(modelAcc) + int'(imm) + int'(cin);
			end
			`OP_SUB: total = int'(modelAcc) - int'(imm);   // Negative on borrow
			`OP_AND: total = int'(modelAcc & imm);
			`OP_XOR: total = int'(modelAcc ^ imm);
			default: total = int'(imm);
		endcase
		modelAcc   = total[`DATA_W-1:0];
		modelZero  = (modelAcc == 8'h00);
		modelCarry = (total > 255) || (total < 0);
	endtask

	// FETCH, OPERAND, EXEC, then check in the next FETCH
	task automatic runAlu(input logic [`DATA_W-1:0] op, input logic [`DATA_W-1:0] imm);
		checkBit("busRd", busRd, 1'b1);
		dataIn = op;
		nextCycle();
		checkBit("busRd", busRd, 1'b1);        // OPERAND
		dataIn = imm;
		nextCycle();
		checkBit("busRd", busRd, 1'b0);        // EXEC
		dataIn = randByte();                   // Must not reach DL
		modelExec(op, imm);
		nextCycle();
		checkByte("acc", acc, modelAcc);
		checkBit("flags.zero", flags.zero, modelZero);
		checkBit("flags.carry", flags.carry, modelCarry);
	endtask

	// ST or OUTDV, FETCH then WRITE1 then WRITE2
	task automatic runWrite(input logic [`DATA_W-1:0] op);
		logic [`DATA_W-1:0] expOut;
		expOut = (op == `OP_ST) ? modelAcc : modelDv;
		checkBit("dataOe", dataOe, 1'b0);
		dataIn = op;
		nextCycle();
		checkBit("busRd", busRd, 1'b0);        // WRITE1
		checkBit("dataOe", dataOe, 1'b0);
		dataIn = randByte();
		nextCycle();
		checkBit("dataOe", dataOe, 1'b1);      // WRITE2
		checkByte("dataOut", dataOut, expOut);
		nextCycle();
		checkBit("dataOe", dataOe, 1'b0);
		checkByte("acc", acc, modelAcc);
	endtask

	task automatic runNop();
		dataIn = `OP_NOP;
		nextCycle();
		checkBit("busRd", busRd, 1'b1);
	endtask

	// Config write during a NOP fetch
	task automatic writeCfg(input logic dis, input logic useC);
		cfgWdata = '{busDisable: dis, useCarry: useC};
		cfgWe    = 1'b1;
		dataIn   = `OP_NOP;
		nextCycle();
		cfgWe         = 1'b0;
		modelUseCarry = useC;
	endtask

	// Hostile byte on the bus while cut off
	task automatic disabledCycle(input logic [`DATA_W-1:0] hostile);
		dataIn = hostile;
		nextCycle();
		checkBit("dataOe", dataOe, 1'b0);
		checkBit("busRd", busRd, 1'b1);        // Decoder keeps fetching NOP
		checkByte("acc", acc, modelAcc);
	endtask

	initial begin
		void'($urandom(32'h3fd3));
		arstN         = 1'b0;
		dataIn        = `OP_NOP;
		cfgWe         = 1'b0;
		cfgWdata      = cfg_t'(`CFG_RESET);
		modelAcc      = `DATA_RESET;
		modelDv       = `DATA_RESET;
		modelZero     = 1'b0;
		modelCarry    = 1'b0;
		modelUseCarry = 1'b0;
		disabledPhase = 1'b0;
		repeat (5) @(posedge CLK);
		#10;
		arstN = 1'b1;

		checkBit("dataOe", dataOe, 1'b0);
		checkBit("busRd", busRd, 1'b1);
		checkByte("acc", acc, 8'h00);

		repeat (4) begin                       // Random ALU rounds
			runAlu(`OP_LDI, randByte());
			runAlu(`OP_ADD, randByte());
			runAlu(`OP_ADC, randByte());
			runAlu(`OP_SUB, randByte());
			runAlu(`OP_AND, randByte());
			runAlu(`OP_XOR, randByte());
		end
		runAlu(`OP_XOR, modelAcc);             // Forces the zero flag

		repeat (3) begin                       // Stores of acc and DV
			runAlu(`OP_LDI, randByte());
			runWrite(`OP_ST);
			runAlu(`OP_XOR, randByte());
			runWrite(`OP_OUTDV);
		end

		writeCfg(1'b0, 1'b1);                  // Carry mode on
		checkBit("cfgRdata.useCarry", cfgRdata.useCarry, 1'b0);
		runNop();
		checkBit("cfgRdata.useCarry", cfgRdata.useCarry, 1'b1);
		runAlu(`OP_LDI, 8'hF0);
		runAlu(`OP_ADD, 8'h20);                // Overflows, carry set
		runAlu(`OP_ADD, 8'h05);
		checkByte("acc", acc, 8'h16);          // 10 + 05 + carry
		writeCfg(1'b0, 1'b0);

		runAlu(`OP_LDI, randByte() | 8'h01);   // Nonzero acc to watch
		writeCfg(1'b1, 1'b0);                  // Keeper takes NOP on this edge
		checkBit("cfgRdata.busDisable", cfgRdata.busDisable, 1'b0);
		disabledPhase = 1'b1;
		repeat (2) begin
			disabledCycle(`OP_ST);
			disabledCycle(`OP_LDI);
			disabledCycle(`OP_OUTDV);
			disabledCycle(`OP_ADD);
		end
		checkBit("cfgRdata.busDisable", cfgRdata.busDisable, 1'b1);
		writeCfg(1'b0, 1'b0);
		disabledPhase = 1'b0;
		runAlu(`OP_LDI, randByte());           // Normal fetches again
		checkBit("cfgRdata.busDisable", cfgRdata.busDisable, 1'b0);
		runAlu(`OP_ADD, randByte());
		runWrite(`OP_ST);

		$display("Checks %0d, check errors %0d, property errors %0d",
			checkCount, errCount, propErrCount);
		if (errCount == 0 && propErrCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule : tbDataPath
